//--- Makefile
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: obj_dir/Vtb_line_buffer

obj_dir/Vtb_line_buffer: verilog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_line_buffer -f verilog.f

run: obj_dir/Vtb_line_buffer
	./obj_dir/Vtb_line_buffer

clean:
	rm -rf obj_dir

//--- flow_ram.sv
`default_nettype none

module flow_ram #(
    parameter type word_t = logic [7:0],
    parameter int depth = 2
) (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire logic [$clog2(depth)-1:0] waddr,
    input  wire logic [$clog2(depth)-1:0] raddr,
    input  wire word_t                    wdata,
    output word_t                         rdata
);

    word_t mem [depth];

    // write lands at the edge
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // combinational read, sees the old word during a write cycle
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

//--- flow_select.sv
`default_nettype none

module flow_select (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [line_pkg::num_flows-1:0] pel_empty,
    input  wire logic [line_pkg::num_flows-1:0] size_empty,
    input  wire logic [line_pkg::num_flows-1:0] out_full,
    input  wire line_pkg::pel_beat_t           pel_in [line_pkg::num_flows],
    input  wire line_pkg::frame_size_t         size_in [line_pkg::num_flows],
    output logic [line_pkg::num_flows-1:0]     pel_read,
    output logic [line_pkg::num_flows-1:0]     size_read,
    output logic                               cmd_valid,
    output line_pkg::line_cmd_t                cmd
);

    logic [line_pkg::num_flows-1:0] working;
    logic [line_pkg::num_flows-1:0] ready;
    logic                           fire;
    line_pkg::flow_t                fire_tag;
    logic                           line_fire;
    logic [line_pkg::size_w-1:0]    line_beats;
    line_pkg::flow_ctx_t            ctx_rd;
    line_pkg::flow_ctx_t            cur;
    line_pkg::flow_ctx_t            nxt;

    // per-flow context, read and written back in the firing cycle
    flow_ram #(
        .word_t(line_pkg::flow_ctx_t),
        .depth (line_pkg::num_flows)
    ) ctx_mem0 (
        .clk  (clk),
        .we   (fire),
        .waddr(fire_tag),
        .raddr(fire_tag),
        .wdata(nxt),
        .rdata(ctx_rd)
    );

    always_comb
    begin
        for (int i = 0; i < line_pkg::num_flows; i++)
        begin
            ready[i] = working[i] ? (!pel_empty[i] && !out_full[i]) : !size_empty[i];
        end
    end

    // fixed priority, lowest ready flow wins
    always_comb
    begin
        fire = 1'b0;
        fire_tag = '0;
        for (int i = line_pkg::num_flows - 1; i >= 0; i--)
        begin
            if (ready[i])
            begin
                fire = 1'b1;
                fire_tag = line_pkg::flow_t'(i);
            end
        end
    end

    // state bit comes from the reset vector, not the memory
    always_comb
    begin
        cur = ctx_rd;
        cur.working = working[fire_tag];
    end

    assign line_beats = size_in[fire_tag].real_size >> 3;

    always_comb
    begin
        nxt = cur;
        pel_read = '0;
        size_read = '0;
        line_fire = 1'b0;
        if (fire && !cur.working)
        begin
            // load frame size
            size_read[fire_tag] = 1'b1;
            nxt.working = 1'b1;
            nxt.max_h = line_beats[line_pkg::addr_w-1:0];
            nxt.max_v = size_in[fire_tag].ext_size;
            nxt.cnt_h = '0;
            nxt.cnt_v = '0;
        end
        else if (fire)
        begin
            pel_read[fire_tag] = 1'b1;
            line_fire = 1'b1;
            if (cur.cnt_h < cur.max_h - 1'b1)
            begin
                nxt.cnt_h = cur.cnt_h + 1'b1;
            end
            else if (cur.cnt_v < cur.max_v - 1'b1)
            begin
                nxt.cnt_h = '0;
                nxt.cnt_v = cur.cnt_v + 1'b1;
            end
            else
            begin
                // end of frame
                nxt.cnt_h = '0;
                nxt.cnt_v = '0;
                nxt.working = 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            working <= '0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            if (fire)
            begin
                working[fire_tag] <= nxt.working;
            end
            cmd_valid <= line_fire;
        end
    end

    always_ff @(posedge clk)
    begin
        if (line_fire)
        begin
            cmd.tag <= fire_tag;
            cmd.addr <= cur.cnt_h;
            cmd.beat <= pel_in[fire_tag];
        end
    end

    a_single_read: assert property (@(posedge clk) disable iff (rst)
        $onehot0({pel_read, size_read}));

    a_full_blocks: assert property (@(posedge clk) disable iff (rst)
        (pel_read & out_full) == '0);

endmodule

`default_nettype wire

//--- line_buffer_8p.sv
`default_nettype none

module line_buffer_8p (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic [line_pkg::num_flows-1:0] pel_empty,
    input  wire line_pkg::pel_beat_t            pel_in [line_pkg::num_flows],
    input  wire logic [line_pkg::num_flows-1:0] size_empty,
    input  wire line_pkg::frame_size_t          size_in [line_pkg::num_flows],
    input  wire logic [line_pkg::num_flows-1:0] out_full,
    output logic [line_pkg::num_flows-1:0]      pel_read,
    output logic [line_pkg::num_flows-1:0]      size_read,
    output logic                                out_write,
    output line_pkg::out_beat_t                 out_data
);

    // stage one to stage two
    logic                cmd_valid;
    line_pkg::line_cmd_t cmd;

    flow_select select0 (
        .clk       (clk),
        .rst       (rst),
        .pel_empty (pel_empty),
        .size_empty(size_empty),
        .out_full  (out_full),
        .pel_in    (pel_in),
        .size_in   (size_in),
        .pel_read  (pel_read),
        .size_read (size_read),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    line_store store0 (
        .clk      (clk),
        .rst      (rst),
        .cmd_valid(cmd_valid),
        .cmd      (cmd),
        .out_write(out_write),
        .out_data (out_data)
    );

endmodule

`default_nettype wire

//--- line_pkg.sv
`default_nettype none

package line_pkg;

    // flow count and tag width
    localparam int num_flows = 2;
    localparam int flow_w = $clog2(num_flows);

    // pixel and beat geometry
    localparam int pel_w = 18;
    localparam int pels_per_beat = 8;
    localparam int line_depth = 64;
    localparam int size_w = 7;
    localparam int addr_w = $clog2(line_depth);

    typedef logic [flow_w-1:0] flow_t;

    // pixel 0 sits in the low bits
    typedef logic [pels_per_beat-1:0][pel_w-1:0] pel_beat_t;

    // real_size is in pixels, a multiple of 8
    typedef struct packed {
        logic [size_w-1:0] ext_size;
        logic [size_w-1:0] real_size;
    } frame_size_t;

    typedef struct packed {
        logic              working;
        logic [addr_w-1:0] cnt_h;
        logic [size_w-1:0] cnt_v;
        logic [addr_w-1:0] max_h;
        logic [size_w-1:0] max_v;
    } flow_ctx_t;

    typedef struct packed {
        flow_t             tag;
        logic [addr_w-1:0] addr;
        pel_beat_t         beat;
    } line_cmd_t;

    typedef struct packed {
        flow_t     tag;
        pel_beat_t beat;
    } out_beat_t;

endpackage

`default_nettype wire

//--- line_store.sv
`default_nettype none

module line_store (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                cmd_valid,
    input  wire line_pkg::line_cmd_t cmd,
    output logic                     out_write,
    output line_pkg::out_beat_t      out_data
);

    logic [line_pkg::num_flows-1:0] wr_en;
    line_pkg::pel_beat_t            old_beat [line_pkg::num_flows];

    // one line memory per flow
    for (genvar i = 0; i < line_pkg::num_flows; i++)
    begin : g_line
        assign wr_en[i] = cmd_valid && (cmd.tag == line_pkg::flow_t'(i));

        flow_ram #(
            .word_t(line_pkg::pel_beat_t),
            .depth (line_pkg::line_depth)
        ) line_mem (
            .clk  (clk),
            .we   (wr_en[i]),
            .waddr(cmd.addr),
            .raddr(cmd.addr),
            .wdata(cmd.beat),
            .rdata(old_beat[i])
        );
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_write <= 1'b0;
        end
        else
        begin
            out_write <= cmd_valid;
        end
    end

    // previous line's beat at the same position
    always_ff @(posedge clk)
    begin
        if (cmd_valid)
        begin
            out_data.tag <= cmd.tag;
            out_data.beat <= old_beat[cmd.tag];
        end
    end

    a_tag_range: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> (int'(cmd.tag) < line_pkg::num_flows));

endmodule

`default_nettype wire

//--- tb_line_buffer.sv
`default_nettype none

module tb_line_buffer;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [line_pkg::num_flows-1:0] mask;
        int w0;
        int h0;
        int w1;
        int h1;
        int full_flow;
        int full_from;
        int full_to;
    } case_t;

    typedef struct packed {
        int                  due;
        logic                known;
        line_pkg::out_beat_t data;
    } expect_t;

    localparam int num_cases = 6;

    // flows, width and height per flow in pixels, then out_full flow and its cycle window
    case_t cases [num_cases] = '{
        '{2'b01, 16, 3, 0, 0, 0, 0, 0},
        '{2'b11, 16, 2, 16, 2, 0, 0, 0},
        '{2'b11, 24, 3, 40, 2, 0, 3, 11},
        '{2'b11, 64, 2, 16, 4, 0, 5, 21},
        '{2'b10, 0, 0, 120, 3, 1, 2, 9},
        '{2'b11, 16, 3, 16, 3, 1, 0, 30}
    };

    logic                           clk = 1'b0;
    logic                           rst;
    logic [line_pkg::num_flows-1:0] pel_empty;
    line_pkg::pel_beat_t            pel_in [line_pkg::num_flows];
    logic [line_pkg::num_flows-1:0] size_empty;
    line_pkg::frame_size_t          size_in [line_pkg::num_flows];
    logic [line_pkg::num_flows-1:0] out_full;
    logic [line_pkg::num_flows-1:0] pel_read;
    logic [line_pkg::num_flows-1:0] size_read;
    logic                           out_write;
    line_pkg::out_beat_t            out_data;

    // source queues, head shown while non-empty
    line_pkg::frame_size_t size_q [line_pkg::num_flows][$];
    line_pkg::pel_beat_t   pel_q [line_pkg::num_flows][$];
    expect_t               exp_q [$];

    // reference model
    logic [line_pkg::num_flows-1:0] m_working;
    int                             m_cnt_h [line_pkg::num_flows];
    int                             m_cnt_v [line_pkg::num_flows];
    int                             m_max_h [line_pkg::num_flows];
    int                             m_max_v [line_pkg::num_flows];
    line_pkg::pel_beat_t            line_model [line_pkg::num_flows][line_pkg::line_depth];
    logic                           written [line_pkg::num_flows][line_pkg::line_depth];

    logic [line_pkg::num_flows-1:0] pop_pel;
    logic [line_pkg::num_flows-1:0] pop_size;
    int                             cycle;
    int                             row_start;
    int                             full_flow;
    int                             full_from;
    int                             full_to;
    logic [31:0]                    lfsr_state = 32'h4eb3_82f5;

    line_buffer_8p dut0 (
        .clk       (clk),
        .rst       (rst),
        .pel_empty (pel_empty),
        .pel_in    (pel_in),
        .size_empty(size_empty),
        .size_in   (size_in),
        .out_full  (out_full),
        .pel_read  (pel_read),
        .size_read (size_read),
        .out_write (out_write),
        .out_data  (out_data)
    );

    always #10 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic line_pkg::pel_beat_t random_beat();
        logic [$bits(line_pkg::pel_beat_t)-1:0] flat;
        for (int k = 0; k < $bits(line_pkg::pel_beat_t); k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            flat[k] = lfsr_state[0];
        end
        return flat;
    endfunction

    function automatic int frame_width(input int r, input int i);
        return (i == 0) ? cases[r].w0 : cases[r].w1;
    endfunction

    function automatic int frame_height(input int r, input int i);
        return (i == 0) ? cases[r].h0 : cases[r].h1;
    endfunction

    function automatic int total_beats();
        int sum;
        sum = 0;
        for (int r = 0; r < num_cases; r++)
        begin
            for (int i = 0; i < line_pkg::num_flows; i++)
            begin
                if (cases[r].mask[i])
                begin
                    sum += frame_width(r, i) / 8 * frame_height(r, i);
                end
            end
        end
        return sum;
    endfunction

    function automatic logic busy();
        logic any;
        any = (exp_q.size() != 0);
        for (int i = 0; i < line_pkg::num_flows; i++)
        begin
            any = any || (pel_q[i].size() != 0) || (size_q[i].size() != 0);
        end
        return any;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flow(input string name, input line_pkg::flow_t got,
                              input line_pkg::flow_t exp);
        if (got !== exp)
        begin
            fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_beat(input string name, input line_pkg::out_beat_t got,
                              input line_pkg::out_beat_t exp);
        if (got !== exp)
        begin
            fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // outputs are stable here, half a cycle after the edge
    task automatic sample_cycle();
        logic [line_pkg::num_flows-1:0] ready;
        logic [line_pkg::num_flows-1:0] want_pel;
        logic [line_pkg::num_flows-1:0] want_size;
        line_pkg::frame_size_t          fs;
        expect_t                        e;
        int                             f;
        int                             addr;
        f = -1;
        want_pel = '0;
        want_size = '0;
        for (int i = 0; i < line_pkg::num_flows; i++)
        begin
            ready[i] = m_working[i] ? (pel_q[i].size() != 0 && !out_full[i])
                                    : (size_q[i].size() != 0);
            if (ready[i] && f < 0)
            begin
                f = i;
            end
        end
        if (f >= 0)
        begin
            want_pel[f] = m_working[f];
            want_size[f] = !m_working[f];
        end
        for (int i = 0; i < line_pkg::num_flows; i++)
        begin
            check_bit($sformatf("pel_read[%0d]", i), pel_read[i], want_pel[i]);
            check_bit($sformatf("size_read[%0d]", i), size_read[i], want_size[i]);
        end
        if (exp_q.size() != 0 && exp_q[0].due == cycle)
        begin
            e = exp_q.pop_front();
            check_bit("out_write", out_write, 1'b1);
            check_flow("out_data.tag", out_data.tag, e.data.tag);
            if (e.known)
            begin
                check_beat("out_data", out_data, e.data);
            end
        end
        else
        begin
            check_bit("out_write", out_write, 1'b0);
        end
        pop_pel = want_pel;
        pop_size = want_size;
        if (f >= 0 && want_size[f])
        begin
            fs = size_q[f][0];
            m_working[f] = 1'b1;
            m_max_h[f] = int'(fs.real_size) / 8;
            m_max_v[f] = int'(fs.ext_size);
            m_cnt_h[f] = 0;
            m_cnt_v[f] = 0;
        end
        else if (f >= 0)
        begin
            addr = m_cnt_h[f];
            e.due = cycle + 2;
            e.known = written[f][addr];
            e.data.tag = line_pkg::flow_t'(f);
            e.data.beat = line_model[f][addr];
            exp_q.push_back(e);
            line_model[f][addr] = pel_q[f][0];
            written[f][addr] = 1'b1;
            if (m_cnt_h[f] < m_max_h[f] - 1)
            begin
                m_cnt_h[f]++;
            end
            else if (m_cnt_v[f] < m_max_v[f] - 1)
            begin
                m_cnt_h[f] = 0;
                m_cnt_v[f]++;
            end
            else
            begin
                m_cnt_h[f] = 0;
                m_cnt_v[f] = 0;
                m_working[f] = 1'b0;
            end
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        cycle++;
        #2;
        for (int i = 0; i < line_pkg::num_flows; i++)
        begin
            if (pop_pel[i])
            begin
                void'(pel_q[i].pop_front());
            end
            if (pop_size[i])
            begin
                void'(size_q[i].pop_front());
            end
            pel_empty[i] = (pel_q[i].size() == 0);
            pel_in[i] = pel_empty[i] ? '0 : pel_q[i][0];
            size_empty[i] = (size_q[i].size() == 0);
            size_in[i] = size_empty[i] ? '0 : size_q[i][0];
            out_full[i] = (i == full_flow) && (cycle - row_start >= full_from)
                          && (cycle - row_start < full_to);
        end
        pop_pel = '0;
        pop_size = '0;
        @(negedge clk);
        sample_cycle();
    endtask

    task automatic run_case(input int r);
        line_pkg::frame_size_t fs;
        int                    want [line_pkg::num_flows];
        row_start = cycle + 1;
        full_flow = cases[r].full_flow;
        full_from = cases[r].full_from;
        full_to = cases[r].full_to;
        for (int i = 0; i < line_pkg::num_flows; i++)
        begin
            want[i] = 0;
            if (cases[r].mask[i])
            begin
                want[i] = frame_width(r, i) / 8 * frame_height(r, i);
                fs.ext_size = line_pkg::size_w'(frame_height(r, i));
                fs.real_size = line_pkg::size_w'(frame_width(r, i));
                size_q[i].push_back(fs);
                for (int b = 0; b < want[i]; b++)
                begin
                    pel_q[i].push_back(random_beat());
                end
            end
        end
        while (busy())
        begin
            step_cycle();
        end
        full_to = 0;
    endtask

    initial
    begin : watchdog
        int limit;
        #1;
        limit = total_beats() * 4 + 200;
        repeat (limit) @(posedge clk);
        fail_run($sformatf("timeout after %0d cycles with data still in flight", limit));
    end

    initial
    begin
        rst = 1'b1;
        pel_empty = '1;
        size_empty = '1;
        out_full = '0;
        pop_pel = '0;
        pop_size = '0;
        m_working = '0;
        cycle = 0;
        row_start = 0;
        full_flow = 0;
        full_from = 0;
        full_to = 0;
        for (int i = 0; i < line_pkg::num_flows; i++)
        begin
            pel_in[i] = '0;
            size_in[i] = '0;
            for (int a = 0; a < line_pkg::line_depth; a++)
            begin
                written[i][a] = 1'b0;
            end
        end
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        // idle stretch with every source empty
        repeat (5) step_cycle();
        for (int r = 0; r < num_cases; r++)
        begin
            run_case(r);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
line_pkg.sv
flow_ram.sv
flow_select.sv
line_store.sv
line_buffer_8p.sv
tb_line_buffer.sv
